/* filelist.f */
src/sysRegPkg.sv
src/regBusIf.sv
src/regAccessFsm.sv
src/taskTimer.sv
src/sysRegFile.sv
src/sysRegUnit.sv
sim/tbSysRegUnit.sv

/* Bender.yml */
package:
  name: sys_reg_unit

sources:
  - src/sysRegPkg.sv
  - src/regBusIf.sv
  - src/regAccessFsm.sv
  - src/taskTimer.sv
  - src/sysRegFile.sv
  - src/sysRegUnit.sv
  - target: simulation
    files:
      - sim/tbSysRegUnit.sv

/* sim/tbSysRegUnit.sv */
`timescale 1ns/1ns

module tbSysRegUnit;
	import sysRegPkg::*;

	localparam int WD_WIDTH = 12;
	localparam int NUM_RAND = 40;
	localparam int NUM_UNMAPPED = 20;
	// random pairs, unmapped reads and the timer phases
	localparam int NUM_ACCESSES = 2 * NUM_RAND + NUM_UNMAPPED + 16;
	localparam int TIMEOUT_CYCLES = NUM_ACCESSES * 8 + 3 * (1 << WD_WIDTH);

	logic CLK;
	logic RESETn;
	logic ACT;
	logic NEXT;
	logic CMD;
	regIdx_t IDX;
	regData_t DATO;
	byteEn_t BE;
	reqTag_t TAGO;
	logic DRDY;
	regData_t DATI;
	reqTag_t TAGI;
	logic TCK;
	logic TCKOVR;
	logic HALT;
	logic TIMEREN;
	logic PTINTR;

	logic [31:0] rngState;
	int pulseCount = 0;
	reqTag_t tagQueue[$];
	// shadow registers
	regData_t dtModel;
	regData_t taskModel;

	sysRegUnit #(
		.WD_WIDTH(WD_WIDTH)
	) uut (
		.CLK(CLK),
		.RESETn(RESETn),
		.ACT(ACT),
		.NEXT(NEXT),
		.CMD(CMD),
		.IDX(IDX),
		.DATO(DATO),
		.BE(BE),
		.TAGO(TAGO),
		.DRDY(DRDY),
		.DATI(DATI),
		.TAGI(TAGI),
		.TCK(TCK),
		.TCKOVR(TCKOVR),
		.HALT(HALT),
		.TIMEREN(TIMEREN),
		.PTINTR(PTINTR)
	);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	// cycles with PTINTR high, sampled on rising edges
	always @(posedge CLK) begin
		if (PTINTR) begin
			pulseCount++;
		end
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge CLK);
		$display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Test FAILED");
		$fatal(1);
	end

	// ----------------------------------------------------------
	// helpers
	// ----------------------------------------------------------
	function automatic logic [31:0] nextRand();
		rngState = rngState * 32'd1664525 + 32'd1013904223;
		return rngState;
	endfunction

	function automatic regData_t randomData();
		return {nextRand(), nextRand()};
	endfunction

	// active-low lanes take the new byte
	function automatic regData_t mergeLanes(input regData_t old, input regData_t data,
			input byteEn_t be);
		for (int i = 0; i < 8; i++) begin
			if (!be[i]) begin
				old[8*i +: 8] = data[8*i +: 8];
			end
		end
		return old;
	endfunction

	// next task entry, back to zero at the limit
	function automatic regData_t advancePointer(input regData_t taskWord);
		logic [15:0] ptr;
		ptr = taskWord[47:32] + 16'd1;
		if (ptr == taskWord[63:48]) begin
			ptr = 16'd0;
		end
		taskWord[47:32] = ptr;
		return taskWord;
	endfunction

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic checkData(input string name, input regData_t expected, input regData_t actual);
		if (expected !== actual) begin
			$display("ERR %s expected %h actual %h", name, expected, actual);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	task automatic checkTag(input string name, input reqTag_t expected, input reqTag_t actual);
		if (expected !== actual) begin
			$display("ERR %s expected %h actual %h", name, expected, actual);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	task automatic checkCount(input string name, input timerCount_t expected,
			input timerCount_t actual);
		if (expected !== actual) begin
			$display("ERR %s expected %h actual %h", name, expected, actual);
			$display("Test FAILED");
			$fatal(1);
		end
	endtask

	// ----------------------------------------------------------
	// request handshake
	// ----------------------------------------------------------
	// returns on the edge that accepts the request
	task automatic issueRequest(input logic isRead, input regIdx_t idx, input regData_t data,
			input byteEn_t be, input reqTag_t tag);
		@(posedge CLK);
		ACT <= 1'b1;
		CMD <= isRead;
		IDX <= idx;
		DATO <= data;
		BE <= be;
		TAGO <= tag;
		@(negedge CLK);
		while (!NEXT) @(negedge CLK);
		@(posedge CLK);
		ACT <= 1'b0;
	endtask

	task automatic writeReg(input regIdx_t idx, input regData_t data, input byteEn_t be);
		logic [31:0] r;
		r = nextRand();
		issueRequest(1'b0, idx, data, be, r[20:0]);
		if (idx == REG_DTR) begin
			dtModel = mergeLanes(dtModel, data, be);
		end else if (idx == REG_TASK) begin
			taskModel = mergeLanes(taskModel, data, be);
		end
		@(negedge CLK);
		if (NEXT) abortRun("NEXT stayed high after a write was accepted");
		while (!NEXT) begin
			if (DRDY) abortRun("DRDY came back for a write");
			@(negedge CLK);
		end
	endtask

	task automatic readReg(input string name, input regIdx_t idx, output regData_t data);
		logic [31:0] r;
		r = nextRand();
		tagQueue.push_back(r[20:0]);
		issueRequest(1'b1, idx, '0, '1, r[20:0]);
		@(negedge CLK);
		while (!DRDY) begin
			if (NEXT) abortRun("NEXT rose before the read response");
			@(negedge CLK);
		end
		if (NEXT) abortRun("NEXT high during the read response");
		data = DATI;
		checkTag(name, tagQueue.pop_front(), TAGI);
		@(negedge CLK);
		if (DRDY) abortRun("DRDY stayed high for more than one cycle");
		if (!NEXT) abortRun("NEXT did not return after the read response");
	endtask

	// exactly one PTINTR within maxCycles falling edges
	task automatic expectSwitch(input string name, input int maxCycles);
		int startCount;
		int cycles;
		startCount = pulseCount;
		cycles = 0;
		while (pulseCount == startCount) begin
			@(negedge CLK);
			cycles++;
			if (cycles > maxCycles) begin
				abortRun($sformatf("%s, no PTINTR within %0d cycles", name, maxCycles));
			end
		end
		repeat (8) @(negedge CLK);
		if (pulseCount != startCount + 1) abortRun($sformatf("%s, extra PTINTR pulse", name));
	endtask

	// ----------------------------------------------------------
	// test sequence
	// ----------------------------------------------------------
	initial begin
		regData_t d;
		regIdx_t idx;
		logic [31:0] r;
		timerCount_t base;
		logic [15:0] limit;
		int pulsesBefore;
		rngState = 32'hbef;
		dtModel = '0;
		taskModel = '0;
		RESETn <= 1'b0;
		ACT <= 1'b0;
		CMD <= 1'b0;
		IDX <= '0;
		DATO <= '0;
		BE <= '1;
		TAGO <= '0;
		TCK <= 1'b0;
		TCKOVR <= 1'b0;
		HALT <= 1'b0;
		TIMEREN <= 1'b0;
		repeat (16) @(posedge CLK);
		RESETn <= 1'b1;
		@(negedge CLK);
		if (!NEXT || DRDY || PTINTR) abortRun("outputs not at their reset values");

		// random byte-lane writes, each read back
		for (int i = 0; i < NUM_RAND; i++) begin
			r = nextRand();
			idx = r[16] ? REG_TASK : REG_DTR;
			writeReg(idx, randomData(), r[31:24]);
			readReg("random write readback", idx, d);
			checkData("random write readback", (idx == REG_DTR) ? dtModel : taskModel, d);
		end

		// unmapped indices read as zero
		for (int i = 0; i < NUM_UNMAPPED; i++) begin
			idx = REG_DTR;
			while (idx == REG_DTR || idx == REG_TASK || idx == REG_TIMER) begin
				r = nextRand();
				idx = r[19:16];
			end
			readReg("unmapped read", idx, d);
			checkData("unmapped read", '0, d);
		end

		// timer expiry, pointer advance and wrap
		r = nextRand();
		base = {10'd0, r[21:16]} + 16'd20;
		limit = {12'd0, r[27:24]} + 16'd4;
		writeReg(REG_TIMER, {48'd0, base}, 8'hfc);
		@(posedge CLK);
		TIMEREN <= 1'b1;
		TCK <= 1'b1;
		r = nextRand();
		writeReg(REG_TASK, {limit, limit - 16'd2, 1'b1, r[30:0]}, 8'h00);
		for (int run = 0; run < 2; run++) begin
			writeReg(REG_TIMER, {48'd0, base}, 8'hfc);
			expectSwitch("timer expiry", base + 4);
			taskModel = advancePointer(taskModel);
			readReg("pointer advance", REG_TASK, d);
			checkData("pointer advance", taskModel, d);
		end

		// halted timer holds, then tick override
		@(posedge CLK);
		HALT <= 1'b1;
		writeReg(REG_TIMER, {48'd0, base}, 8'hfc);
		pulsesBefore = pulseCount;
		readReg("halted timer", REG_TIMER, d);
		checkCount("halted count", base, d[31:16]);
		checkCount("timer base", base, d[15:0]);
		repeat (20) @(negedge CLK);
		readReg("halted timer", REG_TIMER, d);
		checkCount("halted count hold", base, d[31:16]);
		@(posedge CLK);
		TCKOVR <= 1'b1;
		@(posedge CLK);
		TCKOVR <= 1'b0;
		readReg("tick override", REG_TIMER, d);
		checkCount("override count", 16'd2, d[31:16]);
		if (pulseCount != pulsesBefore) abortRun("PTINTR fired while the timer was halted");
		@(posedge CLK);
		HALT <= 1'b0;
		expectSwitch("override expiry", 6);
		taskModel = advancePointer(taskModel);
		readReg("override pointer", REG_TASK, d);
		checkData("override pointer", taskModel, d);

		// timer idle at zero, watchdog switch keeps the pointer
		expectSwitch("watchdog", (1 << WD_WIDTH) + 4);
		readReg("watchdog pointer", REG_TASK, d);
		checkData("watchdog pointer", taskModel, d);

		$display("Test OK");
		$finish;
	end

endmodule

/* src/sysRegUnit.sv */
`timescale 1ns/1ns

module sysRegUnit #(
	parameter int WD_WIDTH = 12
) (
	input logic CLK,
	input logic RESETn,
	input logic ACT,
	output logic NEXT,
	input logic CMD,
	input sysRegPkg::regIdx_t IDX,
	input sysRegPkg::regData_t DATO,
	input sysRegPkg::byteEn_t BE,
	input sysRegPkg::reqTag_t TAGO,
	output logic DRDY,
	output sysRegPkg::regData_t DATI,
	output sysRegPkg::reqTag_t TAGI,
	input logic TCK,
	input logic TCKOVR,
	input logic HALT,
	input logic TIMEREN,
	output logic PTINTR
);
	import sysRegPkg::*;

	timerCount_t timerBase;
	timerCount_t timerCount;
	logic wdSwitch;
	logic taskEnable;

	regBusIf bus ();

	// ----------------------------------------------------------
	// requester side
	// ----------------------------------------------------------
	regAccessFsm accessFsm (
		.CLK(CLK),
		.RESETn(RESETn),
		.ACT(ACT),
		.NEXT(NEXT),
		.CMD(CMD),
		.IDX(IDX),
		.DATO(DATO),
		.BE(BE),
		.TAGO(TAGO),
		.DRDY(DRDY),
		.DATI(DATI),
		.TAGI(TAGI),
		.bus(bus.master)
	);

	// ----------------------------------------------------------
	// registers and task timer
	// ----------------------------------------------------------
	taskTimer #(
		.WD_WIDTH(WD_WIDTH)
	) timer (
		.CLK(CLK),
		.RESETn(RESETn),
		.bus(bus.timer),
		.TCK(TCK),
		.TCKOVR(TCKOVR),
		.HALT(HALT),
		.TIMEREN(TIMEREN),
		.taskEnable(taskEnable),
		.timerBase(timerBase),
		.timerCount(timerCount),
		.switchReq(PTINTR),
		.wdSwitch(wdSwitch)
	);

	sysRegFile regFile (
		.CLK(CLK),
		.RESETn(RESETn),
		.bus(bus.slave),
		.timerBase(timerBase),
		.timerCount(timerCount),
		.switchReq(PTINTR),
		.wdSwitch(wdSwitch),
		.taskEnable(taskEnable)
	);

endmodule

/* src/sysRegFile.sv */
`timescale 1ns/1ns

module sysRegFile (
	input logic CLK,
	input logic RESETn,
	regBusIf.slave bus,
	input sysRegPkg::timerCount_t timerBase,
	input sysRegPkg::timerCount_t timerCount,
	input logic switchReq,
	input logic wdSwitch,
	output logic taskEnable
);
	import sysRegPkg::*;

	// descriptor table, limit in 63..40 and base in 39..0
	regData_t dtReg;
	// task table, pointer word in 63..32 and status in 31..0
	regData_t taskReg;

	logic [7:0] dtLaneWr;
	logic [7:0] taskLaneWr;
	logic [15:0] ptrLow;
	logic [15:0] ptrLimit;
	logic [15:0] ptrInc;
	logic [15:0] ptrNext;
	logic ptrAdvance;

	// ----------------------------------------------------------
	// write decode
	// ----------------------------------------------------------
	assign dtLaneWr = {8{bus.wrStrobe && (bus.idx == REG_DTR)}} & ~bus.be;
	assign taskLaneWr = {8{bus.wrStrobe && (bus.idx == REG_TASK)}} & ~bus.be;

	// ----------------------------------------------------------
	// task pointer
	// ----------------------------------------------------------
	assign ptrLow = taskReg[47:32];
	assign ptrLimit = taskReg[63:48];
	assign ptrInc = ptrLow + 16'd1;
	// wrap to entry zero when the limit is reached
	assign ptrNext = (ptrInc == ptrLimit) ? 16'd0 : ptrInc;

	// watchdog switches keep the current task
	assign ptrAdvance = switchReq & ~wdSwitch;

	assign taskEnable = taskReg[31];

	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			dtReg <= '0;
			taskReg <= '0;
		end else begin
			for (int i = 0; i < 8; i++) begin
				if (dtLaneWr[i]) begin
					dtReg[8*i +: 8] <= bus.wdata[8*i +: 8];
				end
				if (taskLaneWr[i]) begin
					taskReg[8*i +: 8] <= bus.wdata[8*i +: 8];
				end
			end
			// a host write to a pointer byte takes priority
			if (ptrAdvance && !taskLaneWr[4]) begin
				taskReg[39:32] <= ptrNext[7:0];
			end
			if (ptrAdvance && !taskLaneWr[5]) begin
				taskReg[47:40] <= ptrNext[15:8];
			end
		end
	end

	// ----------------------------------------------------------
	// read mux
	// ----------------------------------------------------------
	always_comb begin
		case (bus.idx)
			REG_DTR: bus.rdata = dtReg;
			REG_TASK: bus.rdata = taskReg;
			REG_TIMER: bus.rdata = {32'd0, timerCount, timerBase};
			default: bus.rdata = '0;
		endcase
	end

	// an in-range pointer stays in range across an advance
	ptrStaysBelowLimit: assert property (@(posedge CLK) disable iff (!RESETn)
		ptrAdvance && !(|taskLaneWr) && (ptrLow < ptrLimit) |=> ptrLow < ptrLimit);

endmodule

/* src/taskTimer.sv */
`timescale 1ns/1ns

module taskTimer #(
	parameter int WD_WIDTH = 12
) (
	input logic CLK,
	input logic RESETn,
	regBusIf.timer bus,
	input logic TCK,
	input logic TCKOVR,
	input logic HALT,
	input logic TIMEREN,
	input logic taskEnable,
	output sysRegPkg::timerCount_t timerBase,
	output sysRegPkg::timerCount_t timerCount,
	output logic switchReq,
	output logic wdSwitch
);
	import sysRegPkg::*;

	logic [1:0] baseLaneWr;
	logic reloadFlag;
	logic countFlag;
	logic wdExpired;
	logic [WD_WIDTH-1:0] wdCount;

	// base lives in lanes 0 and 1 of the timer register
	assign baseLaneWr = {2{bus.wrStrobe && (bus.idx == REG_TIMER)}} & ~bus.be[1:0];

	// watchdog fires only when the timer is armed
	assign wdExpired = TIMEREN & taskEnable & (&wdCount);

	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			timerBase <= '0;
			timerCount <= '0;
			reloadFlag <= 1'b0;
			countFlag <= 1'b0;
			switchReq <= 1'b0;
			wdSwitch <= 1'b0;
			wdCount <= '0;
		end else begin
			if (baseLaneWr[0]) begin
				timerBase[7:0] <= bus.wdata[7:0];
			end
			if (baseLaneWr[1]) begin
				timerBase[15:8] <= bus.wdata[15:8];
			end
			// writing the high base byte restarts the timer
			reloadFlag <= baseLaneWr[1];

			if (TCKOVR) begin
				timerCount <= TIMER_OVR_VALUE;
			end else if (reloadFlag) begin
				timerCount <= timerBase;
			end else if (countFlag && (timerCount != '0)) begin
				timerCount <= timerCount - 1'b1;
			end
			countFlag <= TCK & (|timerCount) & TIMEREN & taskEnable & ~HALT;

			// end of count or watchdog, one cycle each
			switchReq <= (countFlag & (timerCount == 16'd1)) | wdExpired;
			wdSwitch <= wdExpired;

			// watchdog runs while the timer sits at zero
			if (timerCount == '0) begin
				wdCount <= wdCount + 1'b1;
			end else begin
				wdCount <= '0;
			end
		end
	end

	countNeverRises: assert property (@(posedge CLK) disable iff (!RESETn)
		!$past(TCKOVR) && !$past(reloadFlag) |-> timerCount <= $past(timerCount));

endmodule

/* src/regAccessFsm.sv */
`timescale 1ns/1ns

module regAccessFsm (
	input logic CLK,
	input logic RESETn,
	input logic ACT,
	output logic NEXT,
	input logic CMD,
	input sysRegPkg::regIdx_t IDX,
	input sysRegPkg::regData_t DATO,
	input sysRegPkg::byteEn_t BE,
	input sysRegPkg::reqTag_t TAGO,
	output logic DRDY,
	output sysRegPkg::regData_t DATI,
	output sysRegPkg::reqTag_t TAGI,
	regBusIf.master bus
);
	import sysRegPkg::*;

	accState_t state;
	reqTag_t tagReg;
	logic accept;

	// requests are only taken while idle
	assign NEXT = (state == IDLE);
	assign accept = ACT & NEXT;

	// ----------------------------------------------------------
	// sequencer
	// ----------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (!RESETn) begin
			state <= IDLE;
			bus.wrStrobe <= 1'b0;
			bus.rdStrobe <= 1'b0;
			DRDY <= 1'b0;
		end else begin
			// strobe rises one cycle into WRITE/READ, lasts one cycle
			bus.wrStrobe <= (state == WRITE) & ~bus.wrStrobe;
			bus.rdStrobe <= (state == READ) & ~bus.rdStrobe;
			DRDY <= bus.rdStrobe;
			case (state)
				IDLE: begin
					if (accept) begin
						state <= CMD ? READ : WRITE;
					end
				end
				WRITE: begin
					if (bus.wrStrobe) begin
						state <= IDLE;
					end
				end
				READ: begin
					if (bus.rdStrobe) begin
						state <= RESPOND;
					end
				end
				RESPOND: state <= IDLE;
				default: state <= IDLE;
			endcase
		end
	end

	// ----------------------------------------------------------
	// request capture and response data
	// ----------------------------------------------------------
	always_ff @(posedge CLK) begin
		if (accept) begin
			bus.idx <= IDX;
			bus.wdata <= DATO;
			bus.be <= BE;
			tagReg <= TAGO;
		end
		// read value sampled at the end of the strobe cycle
		if (bus.rdStrobe) begin
			DATI <= bus.rdata;
			TAGI <= tagReg;
		end
	end

	strobeExclusive: assert property (@(posedge CLK) disable iff (!RESETn)
		!(bus.wrStrobe && bus.rdStrobe));

	drdyInRespond: assert property (@(posedge CLK) disable iff (!RESETn)
		DRDY |-> state == RESPOND);

endmodule

/* src/regBusIf.sv */
`timescale 1ns/1ns

interface regBusIf;
	import sysRegPkg::*;

	// one-cycle access pulses
	logic wrStrobe;
	logic rdStrobe;

	// access held stable by the sequencer
	regIdx_t idx;
	regData_t wdata;
	byteEn_t be;

	// selected register, combinational from idx
	regData_t rdata;

	modport master (
		output wrStrobe,
		output rdStrobe,
		output idx,
		output wdata,
		output be,
		input rdata
	);

	modport slave (
		input wrStrobe,
		input idx,
		input wdata,
		input be,
		output rdata
	);

	// timer only watches writes
	modport timer (
		input wrStrobe,
		input idx,
		input wdata,
		input be
	);

endinterface

/* src/sysRegPkg.sv */
package sysRegPkg;

	// ----------------------------------------------------------
	// data path widths
	// ----------------------------------------------------------

	// one register word
	typedef logic [63:0] regData_t;

	// register index, address bits 6..3 of the system window
	typedef logic [3:0] regIdx_t;

	// byte enables, a zero bit selects the lane
	typedef logic [7:0] byteEn_t;

	// requester tag, returned with the read data
	typedef logic [20:0] reqTag_t;

	// task timer count and reload base
	typedef logic [15:0] timerCount_t;

	// ----------------------------------------------------------
	// access sequencer
	// ----------------------------------------------------------
	typedef enum logic [1:0] {
		IDLE,
		WRITE,
		READ,
		RESPOND
	} accState_t;

	// ----------------------------------------------------------
	// register map
	// ----------------------------------------------------------
	localparam regIdx_t REG_DTR = 4'd0;
	localparam regIdx_t REG_TASK = 4'd3;
	localparam regIdx_t REG_TIMER = 4'd8;

	// count forced by the tick override
	localparam timerCount_t TIMER_OVR_VALUE = 16'd2;

endpackage
